// File: src.f
verilog/core_pkg.sv
verilog/pipe_if.sv
verilog/fetch_request.sv
verilog/fetch_main.sv
verilog/decode_main.sv
verilog/execute_main.sv
verilog/result_main.sv
verilog/core_top.sv
verif/tb_clock.sv
verif/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_core \
        --Mdir obj_dir -o sim_core -f src.f > build.log 2>&1
if [ $? -ne 0 ]; then
        cat build.log
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -qx "Test OK" sim.log; then
        exit 0
fi
exit 1

// File: verif/tb_core.sv
module tb_core;

timeunit 1ns;
timeprecision 1ps;

localparam int          NUM_EXPECTED = 16;
localparam int          WAIT_LIMIT   = 400;     // Cycles allowed per handshake phase.
localparam int          QUIET_CYCLES = 40;      // Silence checked after an abort.
localparam int          TAIL_CYCLES  = 80;
localparam logic [31:0] SEED         = 32'hfc5aef33;
localparam logic [31:0] ABORT_ADDR   = 32'h58;  // Word 22.
localparam logic [31:0] RESTART_PC   = 32'h80;  // Word 32.

typedef struct packed {
        logic [core_pkg::REG_W-1:0]  rd;
        logic [core_pkg::WORD_W-1:0] data;
        logic                        abort;     // Also starts the restart step.
} expect_t;

logic                        clk;
logic                        reset;
logic                        restart;
logic [core_pkg::WORD_W-1:0] restart_pc;
logic                        fetch_ack;
logic [core_pkg::WORD_W-1:0] fetch_instr;
logic                        fetch_abort;
logic                        fetch_req;
logic [core_pkg::WORD_W-1:0] fetch_addr;
logic                        res_ack;
logic                        res_req;
logic [core_pkg::REG_W-1:0]  res_rd;
logic [core_pkg::WORD_W-1:0] res_data;
logic                        res_abort;
logic [31:0]                 res_seed = SEED;
int                          checked = 0;
int                          value_errors = 0;
int                          extra_results = 0;
int                          timeouts = 0;
int                          fetch_timeouts = 0;

tb_clock u_clock (.o_clk(clk), .o_reset(reset));

core_top #(.NUM_REGS(16)) dut (
        .i_clk(clk), .i_reset(reset), .i_restart(restart), .i_restart_pc(restart_pc),
        .i_fetch_ack(fetch_ack), .i_fetch_instr(fetch_instr), .i_fetch_abort(fetch_abort),
        .o_fetch_req(fetch_req), .o_fetch_addr(fetch_addr), .i_res_ack(res_ack),
        .o_res_req(res_req), .o_res_rd(res_rd), .o_res_data(res_data),
        .o_res_abort(res_abort)
);

function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] encode(input core_pkg::opcode_e op,
        input logic [core_pkg::REG_W-1:0] rd, input logic [core_pkg::REG_W-1:0] rn,
        input logic [core_pkg::REG_W-1:0] rm, input logic [core_pkg::IMM_W-1:0] imm);
        return {op, rd, rn, rm, imm};
endfunction

// Program by word address. Everything else reads as NOP.
function automatic logic [31:0] instr_at(input logic [31:0] addr);
        case (addr >> 2)
        0:  return encode(core_pkg::MOVI, 4'd1, 4'd0, 4'd0, 16'h1234);
        1:  return encode(core_pkg::MOVI, 4'd2, 4'd0, 4'd0, 16'h0f0f);
        2:  return encode(core_pkg::ADD, 4'd3, 4'd1, 4'd2, 16'h0);
        3:  return encode(core_pkg::SUB, 4'd4, 4'd3, 4'd1, 16'h0);
        4:  return encode(core_pkg::AND, 4'd5, 4'd4, 4'd3, 16'h0);
        5:  return encode(core_pkg::ORR, 4'd6, 4'd5, 4'd1, 16'h0);
        6:  return encode(core_pkg::SUB, 4'd7, 4'd1, 4'd6, 16'h0);
        7:  return encode(core_pkg::B, 4'd0, 4'd0, 4'd0, 16'd10);
        8:  return encode(core_pkg::MOVI, 4'd1, 4'd0, 4'd0, 16'hdead);    // Branch shadow.
        9:  return encode(core_pkg::MOVI, 4'd2, 4'd0, 4'd0, 16'hbeef);
        10: return encode(core_pkg::BL, 4'd8, 4'd0, 4'd0, 16'd14);
        11: return encode(core_pkg::MOVI, 4'd3, 4'd0, 4'd0, 16'hbad0);    // Branch shadow.
        14: return encode(core_pkg::SETM, 4'd0, 4'd0, 4'd0, 16'd1);        // Compact mode.
        15: return encode(core_pkg::BL, 4'd9, 4'd0, 4'd0, 16'd20);
        16: return encode(core_pkg::ADD, 4'd1, 4'd1, 4'd1, 16'h0);
        20: return encode(core_pkg::ADD, 4'd10, 4'd9, 4'd8, 16'h0);
        21: return encode(core_pkg::MOVI, 4'd11, 4'd0, 4'd0, 16'h5a5a);
        22: return encode(core_pkg::MOVI, 4'd12, 4'd0, 4'd0, 16'h1111);   // Fetch aborts.
        23: return encode(core_pkg::MOVI, 4'd13, 4'd0, 4'd0, 16'h2222);
        32: return encode(core_pkg::MOVI, 4'd12, 4'd0, 4'd0, 16'h00ff);   // Restart entry.
        33: return encode(core_pkg::ORR, 4'd13, 4'd12, 4'd3, 16'h0);
        34: return encode(core_pkg::BL, 4'd14, 4'd0, 4'd0, 16'd40);
        35: return encode(core_pkg::MOVI, 4'd15, 4'd0, 4'd0, 16'h3333);
        40: return encode(core_pkg::SUB, 4'd15, 4'd14, 4'd12, 16'h0);
        default: return '0;
        endcase
endfunction

// Results in program order: rd, data, abort.
function automatic expect_t expected_at(input int idx);
        case (idx)
        0:  return {4'd1, 32'h0000_1234, 1'b0};
        1:  return {4'd2, 32'h0000_0f0f, 1'b0};
        2:  return {4'd3, 32'h0000_2143, 1'b0};
        3:  return {4'd4, 32'h0000_0f0f, 1'b0};
        4:  return {4'd5, 32'h0000_0103, 1'b0};
        5:  return {4'd6, 32'h0000_1337, 1'b0};
        6:  return {4'd7, 32'hffff_fefd, 1'b0};
        7:  return {4'd8, 32'h0000_0030, 1'b0};     // Link is PC+8.
        8:  return {4'd9, 32'h0000_0040, 1'b0};     // Link is PC+4 in compact mode.
        9:  return {4'd10, 32'h0000_0070, 1'b0};
        10: return {4'd11, 32'h0000_5a5a, 1'b0};
        11: return {4'd0, ABORT_ADDR, 1'b1};        // Abort reports its PC.
        12: return {4'd12, 32'h0000_00ff, 1'b0};
        13: return {4'd13, 32'h0000_21ff, 1'b0};
        14: return {4'd14, 32'h0000_0090, 1'b0};
        15: return {4'd15, 32'hffff_ff91, 1'b0};
        default: return '0;
        endcase
endfunction

task automatic check_rd(input int idx, input logic [core_pkg::REG_W-1:0] got,
                        input logic [core_pkg::REG_W-1:0] want);
        if (got !== want)
        begin
                $display("error o_res_rd: got %h, expected %h (result %0d)", got, want, idx);
                value_errors++;
        end
endtask

task automatic check_data(input int idx, input logic [core_pkg::WORD_W-1:0] got,
                          input logic [core_pkg::WORD_W-1:0] want);
        if (got !== want)
        begin
                $display("error o_res_data: got %h, expected %h (result %0d)", got, want, idx);
                value_errors++;
        end
endtask

task automatic check_abort(input int idx, input logic got, input logic want);
        if (got !== want)
        begin
                $display("error o_res_abort: got %h, expected %h (result %0d)", got, want, idx);
                value_errors++;
        end
endtask

// One four-phase result exchange with a random ack delay of 0 to 15 cycles.
task automatic collect_result(output logic ok, output logic [core_pkg::REG_W-1:0] rd,
        output logic [core_pkg::WORD_W-1:0] data, output logic abort);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        rd     = '0;
        data   = '0;
        abort  = 1'b0;
        @(posedge clk);
        while (!res_req && cycles < WAIT_LIMIT)
        begin
                @(posedge clk);
                cycles++;
        end
        if (!res_req)
        begin
                $display("timeout: no result request within %0d cycles", WAIT_LIMIT);
                timeouts++;
        end
        else
        begin
                rd       = res_rd;      // Held while req is high.
                data     = res_data;
                abort    = res_abort;
                res_seed = lcg_step(res_seed);
                repeat (res_seed[31:28]) @(posedge clk);
                res_ack <= 1'b1;
                cycles = 0;
                @(posedge clk);
                while (res_req && cycles < WAIT_LIMIT)
                begin
                        @(posedge clk);
                        cycles++;
                end
                if (res_req)
                begin
                        $display("timeout: result request stayed high after the acknowledge");
                        timeouts++;
                end
                else
                        ok = 1'b1;
                res_ack <= 1'b0;        // Return to zero.
        end
endtask

// Any result request here is one too many.
task automatic expect_quiet(input int n);
        logic seen;
        seen = 1'b0;
        repeat (n)
        begin
                @(posedge clk);
                if (res_req && !seen)
                begin
                        $display("unexpected result request: rd %h, data %h", res_rd, res_data);
                        extra_results++;
                        seen = 1'b1;
                end
        end
endtask

task automatic pulse_restart(input logic [core_pkg::WORD_W-1:0] pc);
        @(posedge clk);
        restart    <= 1'b1;
        restart_pc <= pc;
        @(posedge clk);
        restart    <= 1'b0;
endtask

// Instruction memory. Answers each request after 0 to 3 cycles.
initial
begin : memory_responder
        logic [31:0] seed;
        logic [31:0] addr;
        int          cycles;
        seed = SEED;
        fetch_ack   <= 1'b0;
        fetch_instr <= '0;
        fetch_abort <= 1'b0;
        while (fetch_timeouts == 0)
        begin
                cycles = 0;
                @(posedge clk);
                while (!fetch_req && cycles < WAIT_LIMIT)
                begin
                        @(posedge clk);
                        cycles++;
                end
                if (!fetch_req)
                begin
                        $display("timeout: no instruction fetch within %0d cycles", WAIT_LIMIT);
                        fetch_timeouts++;
                end
                else
                begin
                        addr = fetch_addr;      // Stable while req is high.
                        seed = lcg_step(seed);
                        repeat (seed[31:30]) @(posedge clk);
                        fetch_ack   <= 1'b1;
                        fetch_instr <= instr_at(addr);
                        fetch_abort <= (addr == ABORT_ADDR);
                        cycles = 0;
                        @(posedge clk);
                        while (fetch_req && cycles < WAIT_LIMIT)
                        begin
                                @(posedge clk);
                                cycles++;
                        end
                        if (fetch_req)
                        begin
                                $display("timeout: fetch request stayed high after the acknowledge");
                                fetch_timeouts++;
                        end
                        fetch_ack <= 1'b0;
                end
        end
end

initial
begin : main
        expect_t                     want;
        logic [core_pkg::REG_W-1:0]  got_rd;
        logic [core_pkg::WORD_W-1:0] got_data;
        logic                        got_abort;
        logic                        ok;
        int                          idx;
        int                          cycles;
        res_ack    <= 1'b0;
        restart    <= 1'b0;
        restart_pc <= '0;
        cycles = 0;
        @(posedge clk);
        while (reset && cycles < WAIT_LIMIT)
        begin
                @(posedge clk);
                cycles++;
        end
        ok = !reset;
        if (!ok)
        begin
                $display("timeout: reset never released");
                timeouts++;
        end
        idx = 0;
        while (ok && idx < NUM_EXPECTED)
        begin
                want = expected_at(idx);
                collect_result(ok, got_rd, got_data, got_abort);
                if (ok)
                begin
                        checked++;
                        check_rd(idx, got_rd, want.rd);
                        check_data(idx, got_data, want.data);
                        check_abort(idx, got_abort, want.abort);
                        if (want.abort)
                        begin
                                expect_quiet(QUIET_CYCLES);     // Fetch stage asleep.
                                pulse_restart(RESTART_PC);
                        end
                end
                idx++;
        end
        if (ok)
                expect_quiet(TAIL_CYCLES);
        $display("results %0d of %0d, value errors %0d, extra results %0d, timeouts %0d",
                 checked, NUM_EXPECTED, value_errors, extra_results,
                 timeouts + fetch_timeouts);
        if (checked == NUM_EXPECTED && value_errors == 0 && extra_results == 0
            && timeouts == 0 && fetch_timeouts == 0)
                $display("Test OK");
        else
                $display("Test FAILED");
        $finish;
end

endmodule

// File: verif/tb_clock.sv
module tb_clock
(
        output logic o_clk,
        output logic o_reset
);

timeunit 1ns;
timeprecision 1ps;

localparam int RESET_CYCLES = 5;

// 8 ns period.
initial
begin
        o_clk = 1'b0;
        forever
                #4 o_clk = ~o_clk;
end

// Synchronous reset, released on a rising edge.
initial
begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
end

endmodule

// File: verilog/core_top.sv
module core_top
#(
        parameter int NUM_REGS = 16
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_restart,
        input  logic [core_pkg::WORD_W-1:0] i_restart_pc,
        input  logic                        i_fetch_ack,
        input  logic [core_pkg::WORD_W-1:0] i_fetch_instr,
        input  logic                        i_fetch_abort,
        output logic                        o_fetch_req,
        output logic [core_pkg::WORD_W-1:0] o_fetch_addr,
        input  logic                        i_res_ack,
        output logic                        o_res_req,
        output logic [core_pkg::REG_W-1:0]  o_res_rd,
        output logic [core_pkg::WORD_W-1:0] o_res_data,
        output logic                        o_res_abort
);

logic                        stall;
logic                        branch;
logic                        mode;
logic                        clear;
logic                        exec_reset;
logic                        f_valid;
logic                        f_abort;
logic [core_pkg::WORD_W-1:0] target;
logic [core_pkg::WORD_W-1:0] clear_pc;
logic [core_pkg::WORD_W-1:0] f_instr;
logic [core_pkg::WORD_W-1:0] f_pc;
logic [core_pkg::WORD_W-1:0] rdata_a;
logic [core_pkg::WORD_W-1:0] rdata_b;
logic [core_pkg::REG_W-1:0]  rd_a;
logic [core_pkg::REG_W-1:0]  rd_b;

fetch_if  fetch_bus ();
decode_if decode_bus ();
result_if result_bus ();

// Restart beats the stall. A branch waits for the stall to drop.
assign clear      = i_restart || (branch && !stall);
assign clear_pc   = i_restart ? i_restart_pc : target;
assign exec_reset = i_reset || i_restart;      // Also resets the mode bit.

fetch_request u_fetch_request (
        .i_clk, .i_reset, .i_stall(stall), .i_clear(clear), .i_clear_pc(clear_pc),
        .i_fetch_ack, .i_fetch_instr, .i_fetch_abort, .o_fetch_req, .o_fetch_addr,
        .o_valid(f_valid), .o_instr(f_instr), .o_abort(f_abort), .o_pc(f_pc)
);

fetch_main u_fetch_main (
        .i_clk, .i_reset, .i_stall(stall), .i_clear(clear), .i_mode(mode),
        .i_valid(f_valid), .i_instr(f_instr), .i_abort(f_abort), .i_pc(f_pc),
        .o_out(fetch_bus.src)
);

decode_main u_decode_main (
        .i_clk, .i_reset, .i_stall(stall), .i_clear(clear),
        .i_in(fetch_bus.dst), .o_out(decode_bus.src)
);

execute_main #(.NUM_REGS(NUM_REGS)) u_execute_main (
        .i_clk, .i_reset(exec_reset), .i_stall(stall),
        .i_in(decode_bus.dst), .o_out(result_bus.src),
        .o_rd_a(rd_a), .o_rd_b(rd_b), .i_rdata_a(rdata_a), .i_rdata_b(rdata_b),
        .o_branch(branch), .o_target(target), .o_mode(mode)
);

result_main #(.NUM_REGS(NUM_REGS)) u_result_main (
        .i_clk, .i_reset, .i_clear(i_restart), .i_in(result_bus.dst),
        .i_rd_a(rd_a), .i_rd_b(rd_b), .o_rdata_a(rdata_a), .o_rdata_b(rdata_b),
        .o_stall(stall), .o_res_req, .o_res_rd, .o_res_data, .o_res_abort, .i_res_ack
);

endmodule

// File: verilog/result_main.sv
module result_main
#(
        parameter int NUM_REGS = 16
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_clear,
        result_if.dst                       i_in,
        input  logic [core_pkg::REG_W-1:0]  i_rd_a,
        input  logic [core_pkg::REG_W-1:0]  i_rd_b,
        output logic [core_pkg::WORD_W-1:0] o_rdata_a,
        output logic [core_pkg::WORD_W-1:0] o_rdata_b,
        output logic                        o_stall,
        output logic                        o_res_req,
        output logic [core_pkg::REG_W-1:0]  o_res_rd,
        output logic [core_pkg::WORD_W-1:0] o_res_data,
        output logic                        o_res_abort,
        input  logic                        i_res_ack
);

logic [core_pkg::WORD_W-1:0] regs [NUM_REGS];
logic                        ack_wait_ff;       // Req dropped, ack still high.
logic                        accept;

assign o_stall = o_res_req || ack_wait_ff;

// Only writes and aborts go out on the result port.
assign accept = i_in.valid && (i_in.we || i_in.abort) && !o_stall && !i_clear;

// Registers past NUM_REGS read as zero.
assign o_rdata_a = (32'(i_rd_a) < NUM_REGS) ? regs[i_rd_a] : '0;
assign o_rdata_b = (32'(i_rd_b) < NUM_REGS) ? regs[i_rd_b] : '0;

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_res_req   <= 1'b0;
                ack_wait_ff <= 1'b0;
        end
        else if (accept)
                o_res_req <= 1'b1;
        else if (o_res_req && i_res_ack)
        begin
                o_res_req   <= 1'b0;
                ack_wait_ff <= 1'b1;
        end
        else if (ack_wait_ff && !i_res_ack)
                ack_wait_ff <= 1'b0;    // Exchange done.
end

always_ff @(posedge i_clk)
begin
        if (accept)
        begin
                if (i_in.we)
                        regs[i_in.rd] <= i_in.data;
                o_res_rd    <= i_in.abort ? '0 : i_in.rd;
                o_res_data  <= i_in.abort ? i_in.pc : i_in.data;       // Abort reports its PC.
                o_res_abort <= i_in.abort;
        end
end

endmodule

// File: verilog/execute_main.sv
module execute_main
#(
        parameter int NUM_REGS = 16
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_stall,
        decode_if.dst                       i_in,
        result_if.src                       o_out,
        output logic [core_pkg::REG_W-1:0]  o_rd_a,
        output logic [core_pkg::REG_W-1:0]  o_rd_b,
        input  logic [core_pkg::WORD_W-1:0] i_rdata_a,
        input  logic [core_pkg::WORD_W-1:0] i_rdata_b,
        output logic                        o_branch,
        output logic [core_pkg::WORD_W-1:0] o_target,
        output logic                        o_mode
);

localparam int PAD_W = core_pkg::WORD_W - core_pkg::IMM_W;

logic                        take;
logic                        is_branch;
logic                        we;
logic [core_pkg::WORD_W-1:0] op_a;
logic [core_pkg::WORD_W-1:0] op_b;
logic [core_pkg::WORD_W-1:0] result;

assign o_rd_a = i_in.rn;
assign o_rd_b = i_in.rm;

// Item right behind a taken branch is squashed.
assign take      = i_in.valid && !o_branch;
assign is_branch = !i_in.abort && (i_in.opcode inside {core_pkg::B, core_pkg::BL});
assign we        = !i_in.abort && (32'(i_in.rd) < NUM_REGS)
                   && (i_in.opcode inside {core_pkg::ADD, core_pkg::SUB, core_pkg::AND,
                                           core_pkg::ORR, core_pkg::MOVI, core_pkg::BL});

// The item in o_out is not yet written back, so bypass it.
assign op_a = (o_out.valid && o_out.we && o_out.rd == i_in.rn) ? o_out.data : i_rdata_a;
assign op_b = (o_out.valid && o_out.we && o_out.rd == i_in.rm) ? o_out.data : i_rdata_b;

always_comb
begin
        case (i_in.opcode)
        core_pkg::ADD:  result = op_a + op_b;
        core_pkg::SUB:  result = op_a - op_b;
        core_pkg::AND:  result = op_a & op_b;
        core_pkg::ORR:  result = op_a | op_b;
        core_pkg::MOVI: result = {{PAD_W{1'b0}}, i_in.imm};
        core_pkg::BL:   result = i_in.link;     // Link goes to rd.
        default:        result = '0;
        endcase
end

// Branch stays up through a stall and clears after one free cycle.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_out.valid <= 1'b0;
                o_branch    <= 1'b0;
                o_mode      <= 1'b0;    // Normal mode.
        end
        else if (!i_stall)
        begin
                o_out.valid <= take;
                o_out.abort <= i_in.abort;
                o_out.we    <= take && we;
                o_out.rd    <= i_in.rd;
                o_out.data  <= result;
                o_out.pc    <= i_in.pc;
                o_branch    <= take && is_branch;
                o_target    <= {{(PAD_W - 2){1'b0}}, i_in.imm, 2'b00};     // Word address.
                if (take && !i_in.abort && i_in.opcode == core_pkg::SETM)
                        o_mode <= i_in.imm[0];
        end
end

endmodule

// File: verilog/decode_main.sv
module decode_main
(
        input  logic  i_clk,
        input  logic  i_reset,
        input  logic  i_stall,
        input  logic  i_clear,
        fetch_if.dst  i_in,
        decode_if.src o_out
);

logic [core_pkg::OP_W-1:0] raw_op;
core_pkg::opcode_e         opcode;

assign raw_op = i_in.instruction[core_pkg::OP_LSB +: core_pkg::OP_W];

// Unknown codes become NOP.
assign opcode = (raw_op <= core_pkg::SETM) ? core_pkg::opcode_e'(raw_op) : core_pkg::NOP;

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_out.valid <= 1'b0;
                o_out.abort <= 1'b0;
        end
        else if (!i_stall)
        begin
                o_out.valid  <= i_in.valid;
                o_out.abort  <= i_in.abort;     // Rides along with a NOP word.
                o_out.opcode <= opcode;
                o_out.rd     <= i_in.instruction[core_pkg::RD_LSB +: core_pkg::REG_W];
                o_out.rn     <= i_in.instruction[core_pkg::RN_LSB +: core_pkg::REG_W];
                o_out.rm     <= i_in.instruction[core_pkg::RM_LSB +: core_pkg::REG_W];
                o_out.imm    <= i_in.instruction[core_pkg::IMM_W-1:0];
                o_out.pc     <= i_in.pc;
                o_out.link   <= i_in.link;
        end
end

endmodule

// File: verilog/fetch_main.sv
module fetch_main
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_stall,
        input  logic                        i_clear,
        input  logic                        i_mode,    // High in compact mode.
        input  logic                        i_valid,
        input  logic [core_pkg::WORD_W-1:0] i_instr,
        input  logic                        i_abort,
        input  logic [core_pkg::WORD_W-1:0] i_pc,
        fetch_if.src                        o_out
);

localparam logic [core_pkg::WORD_W-1:0] ABORT_WORD   = '0;     // Decodes as NOP.
localparam logic [core_pkg::WORD_W-1:0] LINK_NORMAL  = 8;
localparam logic [core_pkg::WORD_W-1:0] LINK_COMPACT = 4;

// Set by an abort. Only a clear wakes the stage.
logic sleep_ff;

// Clear first, then stall, then sleep, then load.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_out.valid <= 1'b0;
                o_out.abort <= 1'b0;
                sleep_ff    <= 1'b0;
        end
        else if (i_clear)
        begin
                o_out.valid <= 1'b0;
                o_out.abort <= 1'b0;
                sleep_ff    <= 1'b0;    // Wake up.
        end
        else if (i_stall)
        begin
                sleep_ff <= sleep_ff;   // Hold everything.
        end
        else if (sleep_ff)
        begin
                o_out.valid <= 1'b0;
                o_out.abort <= 1'b0;
        end
        else
        begin
                o_out.valid       <= i_valid;
                o_out.abort       <= i_valid && i_abort;
                o_out.instruction <= i_abort ? ABORT_WORD : i_instr;
                o_out.pc          <= i_pc;
                o_out.link        <= i_pc + (i_mode ? LINK_COMPACT : LINK_NORMAL);
                if (i_valid && i_abort)
                        sleep_ff <= 1'b1;
        end
end

endmodule

// File: verilog/fetch_request.sv
module fetch_request
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_stall,
        input  logic                        i_clear,
        input  logic [core_pkg::WORD_W-1:0] i_clear_pc,
        input  logic                        i_fetch_ack,
        input  logic [core_pkg::WORD_W-1:0] i_fetch_instr,
        input  logic                        i_fetch_abort,
        output logic                        o_fetch_req,
        output logic [core_pkg::WORD_W-1:0] o_fetch_addr,
        output logic                        o_valid,
        output logic [core_pkg::WORD_W-1:0] o_instr,
        output logic                        o_abort,
        output logic [core_pkg::WORD_W-1:0] o_pc
);

core_pkg::fetch_state_e      state_ff;
logic [core_pkg::WORD_W-1:0] pc_ff;             // Next fetch address.
logic                        discard_ff;        // Open exchange belongs to a flushed path.

assign o_fetch_req = (state_ff == core_pkg::REQ);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff     <= core_pkg::IDLE;
                pc_ff        <= '0;
                o_fetch_addr <= '0;
                o_valid      <= 1'b0;
                discard_ff   <= 1'b0;
        end
        else
        begin
                if (!i_stall || i_clear)
                        o_valid <= 1'b0;        // Taken by fetch_main, or flushed.

                case (state_ff)
                core_pkg::IDLE:
                        if (!i_stall && !i_clear)
                        begin
                                o_fetch_addr <= pc_ff;  // Stable while req is high.
                                state_ff     <= core_pkg::REQ;
                        end
                core_pkg::REQ:
                        if (i_fetch_ack)
                        begin
                                o_instr    <= i_fetch_instr;
                                o_abort    <= i_fetch_abort;
                                o_pc       <= o_fetch_addr;
                                discard_ff <= 1'b0;
                                state_ff   <= core_pkg::WAIT_ACK_LOW;
                                if (!discard_ff && !i_clear)
                                begin
                                        pc_ff <= o_fetch_addr + 4;
                                        if (i_stall)
                                                state_ff <= core_pkg::HOLD;
                                        else
                                                o_valid <= 1'b1;
                                end
                        end
                        else if (i_clear)
                                discard_ff <= 1'b1;     // Let the exchange finish, drop the word.
                core_pkg::HOLD:
                        if (i_clear)
                                state_ff <= core_pkg::WAIT_ACK_LOW;
                        else if (!i_stall)
                        begin
                                o_valid  <= 1'b1;
                                state_ff <= core_pkg::WAIT_ACK_LOW;
                        end
                core_pkg::WAIT_ACK_LOW:
                        if (!i_fetch_ack)
                                state_ff <= core_pkg::IDLE;     // Return to zero seen.
                default:
                        state_ff <= core_pkg::IDLE;
                endcase

                if (i_clear)
                        pc_ff <= i_clear_pc;
        end
end

endmodule

// File: verilog/pipe_if.sv
// Fetch to decode.
interface fetch_if;
        logic                        valid;
        logic                        abort;
        logic [core_pkg::WORD_W-1:0] instruction;
        logic [core_pkg::WORD_W-1:0] pc;
        logic [core_pkg::WORD_W-1:0] link;      // PC+8, or PC+4 in compact mode.

        modport src (output valid, abort, instruction, pc, link);
        modport dst (input  valid, abort, instruction, pc, link);
endinterface

// Decode to execute.
interface decode_if;
        logic                        valid;
        logic                        abort;
        core_pkg::opcode_e           opcode;
        logic [core_pkg::REG_W-1:0]  rd;
        logic [core_pkg::REG_W-1:0]  rn;
        logic [core_pkg::REG_W-1:0]  rm;
        logic [core_pkg::IMM_W-1:0]  imm;
        logic [core_pkg::WORD_W-1:0] pc;
        logic [core_pkg::WORD_W-1:0] link;

        modport src (output valid, abort, opcode, rd, rn, rm, imm, pc, link);
        modport dst (input  valid, abort, opcode, rd, rn, rm, imm, pc, link);
endinterface

// Execute to result.
interface result_if;
        logic                        valid;
        logic                        abort;
        logic                        we;        // Register write.
        logic [core_pkg::REG_W-1:0]  rd;
        logic [core_pkg::WORD_W-1:0] data;
        logic [core_pkg::WORD_W-1:0] pc;

        modport src (output valid, abort, we, rd, data, pc);
        modport dst (input  valid, abort, we, rd, data, pc);
endinterface

// File: verilog/core_pkg.sv
package core_pkg;

        localparam int WORD_W = 32;     // Data, address and instruction width.
        localparam int REG_W  = 4;      // Register number width.
        localparam int IMM_W  = 16;     // Immediate width.
        localparam int OP_W   = 4;      // Opcode width.

        // Field positions inside an instruction word.
        localparam int OP_LSB = 28;
        localparam int RD_LSB = 24;
        localparam int RN_LSB = 20;
        localparam int RM_LSB = 16;

        // Codes above SETM decode as NOP.
        typedef enum logic [OP_W-1:0] {
                NOP  = 4'd0,
                ADD  = 4'd1,    // rd = rn + rm.
                SUB  = 4'd2,    // rd = rn - rm.
                AND  = 4'd3,
                ORR  = 4'd4,
                MOVI = 4'd5,    // rd = zero-extended imm.
                B    = 4'd6,    // Jump to imm * 4.
                BL   = 4'd7,    // Jump, rd = link.
                SETM = 4'd8     // Mode bit = imm[0].
        } opcode_e;

        // Instruction memory handshake.
        typedef enum logic [1:0] {
                IDLE,
                REQ,
                WAIT_ACK_LOW,
                HOLD            // Word captured during a stall.
        } fetch_state_e;

endpackage
